// ==== program.mem ====
// one 16-bit instruction word per entry, starting at address 0
// opcode[15:12] bit11[11] ra[10:8], then rb[7:5] rc[4:2] or imm8[7:0]
0805 097F 0A80 0BFF 0C00 0D01 0E10 0F00 // immediate loads of r0 to r7
1734 1774 6714 2704 7754 0718           // register-form ALU ops and carry chain
1FF0 6F01 2F03 7FFF                     // immediate-form ALU ops
8980 8000                               // compare, leaves Z=1 C=1 N=0 V=0
5A40 5018 4F40 4718                     // store then load, immediate and indirect
9002 E000 9802 F000 A002 E000 A802 F000 // JZ and JC, plain and inverted
B002 E000 B802 F000 C002 E000 C802 F000 // JN and JGE
D002 E000 D802 F000                     // JGT
8004                                    // compare, leaves Z=0 C=0 N=1 V=0
9002 E000 9802 F000 A002 E000 A802 F000
B002 E000 B802 F000 C002 E000 C802 F000
8100                                    // compare, leaves Z=0 C=1 N=0 V=0
D002 E000 D802 F000
3002 3002 30FF 3000                     // forward, back, forward, final self-jump

// ==== filelist.f ====
cpu_pkg.sv
instruction_decoder.sv
alu.sv
register_file.sv
datapath.sv
program_counter.sv
instruction_rom.sv
data_ram.sv
risc8.sv
tb_clock_gen.sv
tb_risc8.sv

// ==== Bender.yml ====
package:
  name: risc8

sources:
  - cpu_pkg.sv
  - instruction_decoder.sv
  - alu.sv
  - register_file.sv
  - datapath.sv
  - program_counter.sv
  - instruction_rom.sv
  - data_ram.sv
  - risc8.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_risc8.sv

// ==== tb_risc8.sv ====
// RISC8 testbench
`timescale 1ns/1ps
`default_nettype none

module tb_risc8
    import cpu_pkg::*;
();

    localparam int reset_timeout = 10;
    localparam int run_timeout   = 200;
    localparam int hold_cycles   = 4;

    logic                      clk;
    logic                      reset;
    logic [pc_width-1:0]       pc;
    logic                      reg_we;
    logic [reg_addr_width-1:0] reg_waddr;
    logic [data_width-1:0]     reg_wdata;
    logic                      mem_we;
    logic [addr_width-1:0]     mem_addr;
    logic [data_width-1:0]     mem_wdata;
    logic                      flag_c;
    logic                      flag_v;
    logic                      flag_n;
    logic                      flag_z;

    // program image and reference machine state
    logic [15:0]               program_words [rom_depth];
    logic [pc_width-1:0]       model_pc;
    logic [data_width-1:0]     model_regs [reg_count];
    logic [data_width-1:0]     model_ram [2**addr_width];
    logic                      model_c;
    logic                      model_v;
    logic                      model_n;
    logic                      model_z;

    // outputs expected while the current instruction executes
    logic                      exp_reg_we;
    logic [reg_addr_width-1:0] exp_reg_waddr;
    logic [data_width-1:0]     exp_reg_wdata;
    logic                      exp_mem_we;
    logic [addr_width-1:0]     exp_mem_addr;
    logic [data_width-1:0]     exp_mem_wdata;

    tb_clock_gen i_clock_gen (
        .clk,
        .reset
    );

    risc8 i_risc8 (
        .clk, .reset, .pc,
        .reg_we, .reg_waddr, .reg_wdata,
        .mem_we, .mem_addr, .mem_wdata,
        .flag_c, .flag_v, .flag_n, .flag_z
    );

    task automatic check_value(input string test_name, input logic [15:0] expected,
                               input logic [15:0] actual);
        assert (actual === expected) else begin
            $display("CHECK FAILED %s: expected %0h, actual %0h", test_name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "value mismatch in %s", test_name);
        end
    endtask

    function automatic string test_group(input logic [3:0] op);
        case (op)
            op_mov, op_add, op_sub, op_adc, op_sbc: return "arith";
            op_cmp:                                 return "flags";
            op_load, op_store:                      return "memory";
            default:                                return "control";
        endcase
    endfunction

    // executes one instruction on the model and sets the expected outputs
    function automatic void model_step(input logic [15:0] word);
        logic [3:0] op;
        logic       bit11;
        logic [2:0] ra;
        logic [2:0] rb;
        logic [2:0] rc;
        logic [7:0] imm;
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] b_eff;
        logic [7:0] res;
        logic [8:0] full;
        logic       cin;
        logic       use_add;
        logic       c_out;
        logic       v_out;
        logic       taken;
        op    = word[15:12];
        bit11 = word[11];
        ra    = word[10:8];
        rb    = word[7:5];
        rc    = word[4:2];
        imm   = word[7:0];
        if (bit11 || op == op_load || op == op_store || op == op_cmp) begin
            a = model_regs[ra];
        end else begin
            a = model_regs[rb];
        end
        b       = bit11 ? imm : model_regs[rc];
        b_eff   = b;
        cin     = 1'b0;
        use_add = 1'b1;
        case (op)
            op_add: ;
            op_sub, op_cmp: begin
                b_eff = ~b;
                cin   = 1'b1;
            end
            op_adc: cin = model_c;
            op_sbc: begin
                b_eff = ~b;
                cin   = model_c;
            end
            default: use_add = 1'b0;
        endcase
        full  = {1'b0, a} + {1'b0, b_eff} + {8'd0, cin};
        res   = use_add ? full[7:0] : b;
        c_out = use_add && full[8];
        // carry into bit 7 recovered from the sum bit itself
        v_out = use_add && (full[8] ^ res[7] ^ a[7] ^ b_eff[7]);

        exp_reg_we = (op == op_mov || op == op_add || op == op_sub || op == op_adc
                      || op == op_sbc || op == op_load);
        exp_mem_we    = (op == op_store);
        exp_mem_addr  = ((op == op_load || op == op_store) && !bit11) ? model_regs[rc] : imm;
        exp_mem_wdata = model_regs[ra];
        exp_reg_waddr = ra;
        exp_reg_wdata = (op == op_load) ? model_ram[exp_mem_addr] : res;

        // branch decision uses the flags from before this instruction
        case (op)
            op_jmp:  taken = 1'b1;
            op_jz:   taken = model_z ^ bit11;
            op_jc:   taken = model_c ^ bit11;
            op_jn:   taken = model_n ^ bit11;
            op_jge:  taken = (model_n == model_v) ^ bit11;
            op_jgt:  taken = ((model_n == model_v) && !model_z) ^ bit11;
            default: taken = 1'b0;
        endcase
        model_pc = taken ? model_pc + {{8{imm[7]}}, imm} : model_pc + 16'd1;

        if (exp_reg_we) begin
            model_regs[ra] = exp_reg_wdata;
        end
        if (exp_mem_we) begin
            model_ram[exp_mem_addr] = exp_mem_wdata;
        end
        if (exp_reg_we && op != op_load || op == op_cmp) begin
            model_c = c_out;
            model_v = v_out;
            model_n = res[7];
            model_z = (res == 8'd0);
        end
    endfunction

    initial begin
        int                  cycles;
        int                  hold;
        logic [15:0]         word;
        logic [pc_width-1:0] old_pc;
        string               group;
        $readmemh("program.mem", program_words);
        model_pc = '0;
        model_c  = 1'b0;
        model_v  = 1'b0;
        model_n  = 1'b0;
        model_z  = 1'b0;
        group    = "reset";

        // both write strobes stay low for as long as reset is high
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (reset) begin
                check_value("reset reg_we", 16'(1'b0), 16'(reg_we));
                check_value("reset mem_we", 16'(1'b0), 16'(mem_we));
            end
        end while (reset && cycles < reset_timeout);
        if (reset) begin
            $display("timeout: reset was never released");
            $display("TEST FAILED");
            $fatal(1, "reset timeout");
        end

        hold   = 0;
        cycles = 0;
        while (hold < hold_cycles && cycles < run_timeout) begin
            // state left by the previous edge
            check_value({group, " pc"}, model_pc, pc);
            check_value({group, " flag_c"}, 16'(model_c), 16'(flag_c));
            check_value({group, " flag_v"}, 16'(model_v), 16'(flag_v));
            check_value({group, " flag_n"}, 16'(model_n), 16'(flag_n));
            check_value({group, " flag_z"}, 16'(model_z), 16'(flag_z));
            word   = program_words[model_pc[7:0]];
            old_pc = model_pc;
            group  = test_group(word[15:12]);
            model_step(word);
            check_value({group, " reg_we"}, 16'(exp_reg_we), 16'(reg_we));
            check_value({group, " mem_we"}, 16'(exp_mem_we), 16'(mem_we));
            if (exp_reg_we) begin
                check_value({group, " reg_waddr"}, 16'(exp_reg_waddr), 16'(reg_waddr));
                check_value({group, " reg_wdata"}, 16'(exp_reg_wdata), 16'(reg_wdata));
            end
            if (exp_mem_we) begin
                check_value({group, " mem_addr"}, 16'(exp_mem_addr), 16'(mem_addr));
                check_value({group, " mem_wdata"}, 16'(exp_mem_wdata), 16'(mem_wdata));
            end
            hold = (model_pc == old_pc) ? hold + 1 : 0;
            @(negedge clk);
            cycles++;
        end

        if (hold >= hold_cycles) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("timeout: program never reached its final self-jump");
            $display("TEST FAILED");
            $fatal(1, "run timeout");
        end
    end

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
// testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    localparam int half_period = 50;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // reset covers two rising edges, released just after the second
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== risc8.sv ====
// RISC8 processor top
`timescale 1ns/1ps
`default_nettype none

module risc8
    import cpu_pkg::*;
(
    input  wire                         clk,
    input  wire                         reset,
    output wire  [pc_width-1:0]         pc,
    output wire                         reg_we,
    output wire  [reg_addr_width-1:0]   reg_waddr,
    output wire  [data_width-1:0]       reg_wdata,
    output wire                         mem_we,
    output wire  [addr_width-1:0]       mem_addr,
    output wire  [data_width-1:0]       mem_wdata,
    output wire                         flag_c,
    output wire                         flag_v,
    output wire                         flag_n,
    output wire                         flag_z
);

    instr_t                instr;
    logic [data_width-1:0] mem_rdata;

    instruction_rom i_rom (
        .pc,
        .instr
    );

    // RAM is owned by the datapath alone
    data_ram i_ram (
        .clk,
        .we(mem_we),
        .addr(mem_addr),
        .wdata(mem_wdata),
        .rdata(mem_rdata)
    );

    datapath i_datapath (
        .clk, .reset, .instr, .mem_rdata,
        .reg_we, .reg_waddr, .reg_wdata,
        .mem_we, .mem_addr, .mem_wdata,
        .flag_c, .flag_v, .flag_n, .flag_z
    );

    program_counter i_pc (
        .clk, .reset, .instr,
        .flag_c, .flag_v, .flag_n, .flag_z,
        .pc
    );

endmodule

`default_nettype wire

// ==== data_ram.sv ====
// RISC8 data RAM
`timescale 1ns/1ps
`default_nettype none

module data_ram
    import cpu_pkg::*;
(
    input  wire                      clk,
    input  wire                      we,
    input  wire  [addr_width-1:0]    addr,
    input  wire  [data_width-1:0]    wdata,
    output logic [data_width-1:0]    rdata
);

    logic [data_width-1:0] mem [2**addr_width];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // asynchronous read, so LOAD completes in one cycle
    assign rdata = mem[addr];

endmodule

`default_nettype wire

// ==== instruction_rom.sv ====
// RISC8 program ROM
`timescale 1ns/1ps
`default_nettype none

module instruction_rom
    import cpu_pkg::*;
(
    input  wire  [pc_width-1:0] pc,
    output instr_t              instr
);

    logic [$bits(instr_t)-1:0] rom [rom_depth];

    initial begin
        $readmemh("program.mem", rom);
    end

    // pc wraps onto the ROM size
    assign instr = rom[pc[$clog2(rom_depth)-1:0]];

endmodule

`default_nettype wire

// ==== program_counter.sv ====
// RISC8 program counter and branch logic
`timescale 1ns/1ps
`default_nettype none

module program_counter
    import cpu_pkg::*;
(
    input  wire                    clk,
    input  wire                    reset,
    input  wire instr_t            instr,
    input  wire                    flag_c,
    input  wire                    flag_v,
    input  wire                    flag_n,
    input  wire                    flag_z,
    output logic [pc_width-1:0]    pc
);

    logic                cond;
    logic                taken;
    logic [pc_width-1:0] imm_ext;
    logic [pc_width-1:0] step;

    assign imm_ext = {{(pc_width-data_width){instr.imm_form.imm8[data_width-1]}},
                      instr.imm_form.imm8};

    always_comb begin
        cond  = 1'b0;
        taken = 1'b0;
        case (instr.imm_form.opcode)
            op_jmp: taken = 1'b1;
            op_jz:  cond  = flag_z;
            op_jc:  cond  = flag_c;
            op_jn:  cond  = flag_n;
            op_jge: cond  = (flag_n == flag_v);
            op_jgt: cond  = (flag_n == flag_v) && !flag_z;
            default: ;
        endcase
        // bit 11 flips the test of a conditional jump
        if (instr.imm_form.opcode inside {op_jz, op_jc, op_jn, op_jge, op_jgt}) begin
            taken = cond ^ instr.imm_form.imm_en;
        end
    end

    assign step = taken ? imm_ext : pc_width'(1);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= pc + step;
        end
    end

    // flags and the ROM word feed back into pc, so any X would stick
    assert property (@(posedge clk) disable iff (reset) !$isunknown(pc));

endmodule

`default_nettype wire

// ==== datapath.sv ====
// RISC8 datapath
`timescale 1ns/1ps
`default_nettype none

module datapath
    import cpu_pkg::*;
(
    input  wire                        clk,
    input  wire                        reset,
    input  wire instr_t                instr,
    input  wire  [data_width-1:0]      mem_rdata,
    output logic                       reg_we,
    output logic [reg_addr_width-1:0]  reg_waddr,
    output logic [data_width-1:0]      reg_wdata,
    output logic                       mem_we,
    output logic [addr_width-1:0]      mem_addr,
    output logic [data_width-1:0]      mem_wdata,
    output logic                       flag_c,
    output logic                       flag_v,
    output logic                       flag_n,
    output logic                       flag_z
);

    logic [opcode_width-1:0]   opcode;
    logic                      imm_en;
    logic [reg_addr_width-1:0] ra, rb, rc;
    logic [reg_addr_width-1:0] raddr_a;
    logic [data_width-1:0]     imm8, rdata_a, rdata_b, operand_b, alu_result;
    logic                      reg_we_raw, mem_we_raw, flags_we;
    logic                      is_load, is_store;

    instruction_decoder i_decoder (
        .instr, .opcode, .imm_en, .ra, .rb, .rc, .imm8,
        .reg_we_raw, .mem_we_raw, .flags_we
    );

    assign is_load  = (opcode == op_load);
    assign is_store = (opcode == op_store);

    // two-operand forms read and write ra, three-register forms read rb
    assign raddr_a   = (imm_en || is_load || is_store || opcode == op_cmp) ? ra : rb;
    assign operand_b = imm_en ? imm8 : rdata_b;

    register_file i_regs (
        .clk, .we(reg_we), .waddr(reg_waddr), .wdata(reg_wdata),
        .raddr_a, .raddr_b(rc), .rdata_a, .rdata_b
    );

    alu i_alu (
        .clk, .reset, .opcode, .operand_a(rdata_a), .operand_b,
        .flags_we, .result(alu_result), .flag_c, .flag_v, .flag_n, .flag_z
    );

    // register-indirect address comes from rc
    assign mem_addr  = ((is_load || is_store) && !imm_en) ? rdata_b : imm8;
    assign mem_wdata = rdata_a;
    assign mem_we    = mem_we_raw && !reset;

    assign reg_waddr = ra;
    assign reg_wdata = is_load ? mem_rdata : alu_result;
    assign reg_we    = reg_we_raw && !reset;

endmodule

`default_nettype wire

// ==== register_file.sv ====
// RISC8 register file
`timescale 1ns/1ps
`default_nettype none

module register_file
    import cpu_pkg::*;
(
    input  wire                         clk,
    input  wire                         we,
    input  wire  [reg_addr_width-1:0]   waddr,
    input  wire  [data_width-1:0]       wdata,
    input  wire  [reg_addr_width-1:0]   raddr_a,
    input  wire  [reg_addr_width-1:0]   raddr_b,
    output logic [data_width-1:0]       rdata_a,
    output logic [data_width-1:0]       rdata_b
);

    logic [data_width-1:0] regs [reg_count];

    always_ff @(posedge clk) begin
        if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // reads see the old value until the edge
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

endmodule

`default_nettype wire

// ==== alu.sv ====
// RISC8 ALU and flags
`timescale 1ns/1ps
`default_nettype none

module alu
    import cpu_pkg::*;
(
    input  wire                       clk,
    input  wire                       reset,
    input  wire  [opcode_width-1:0]   opcode,
    input  wire  [data_width-1:0]     operand_a,
    input  wire  [data_width-1:0]     operand_b,
    input  wire                       flags_we,
    output logic [data_width-1:0]     result,
    output logic                      flag_c,
    output logic                      flag_v,
    output logic                      flag_n,
    output logic                      flag_z
);

    logic [data_width-1:0] b_eff;
    logic                  carry_in;
    logic                  use_adder;
    logic [data_width:0]   sum_full;
    logic [data_width-1:0] sum_low;
    logic                  c_out;
    logic                  v_out;

    // subtraction is A + ~B + carry
    always_comb begin
        b_eff     = operand_b;
        carry_in  = 1'b0;
        use_adder = 1'b1;
        case (opcode)
            op_add: ;
            op_sub, op_cmp: begin
                b_eff    = ~operand_b;
                carry_in = 1'b1;
            end
            op_adc: carry_in = flag_c;
            op_sbc: begin
                b_eff    = ~operand_b;
                carry_in = flag_c;
            end
            default: use_adder = 1'b0;
        endcase
    end

    assign sum_full = {1'b0, operand_a} + {1'b0, b_eff} + {{data_width{1'b0}}, carry_in};
    // top bit of the low sum is the carry into bit 7
    assign sum_low  = {1'b0, operand_a[data_width-2:0]} + {1'b0, b_eff[data_width-2:0]}
                      + {{(data_width-1){1'b0}}, carry_in};

    // pass-through (MOV) yields no carry and no overflow
    assign result = use_adder ? sum_full[data_width-1:0] : operand_b;
    assign c_out  = use_adder & sum_full[data_width];
    assign v_out  = use_adder & (sum_full[data_width] ^ sum_low[data_width-1]);

    always_ff @(posedge clk) begin
        if (reset) begin
            flag_c <= 1'b0;
            flag_v <= 1'b0;
            flag_n <= 1'b0;
            flag_z <= 1'b0;
        end else if (flags_we) begin
            flag_c <= c_out;
            flag_v <= v_out;
            flag_n <= result[data_width-1];
            flag_z <= (result == '0);
        end
    end

endmodule

`default_nettype wire

// ==== instruction_decoder.sv ====
// RISC8 instruction decoder
`timescale 1ns/1ps
`default_nettype none

module instruction_decoder
    import cpu_pkg::*;
(
    input  wire instr_t                    instr,
    output logic [opcode_width-1:0]        opcode,
    output logic                           imm_en,
    output logic [reg_addr_width-1:0]      ra,
    output logic [reg_addr_width-1:0]      rb,
    output logic [reg_addr_width-1:0]      rc,
    output logic [data_width-1:0]          imm8,
    output logic                           reg_we_raw,
    output logic                           mem_we_raw,
    output logic                           flags_we
);

    // both views share opcode, imm_en and ra
    assign opcode = instr.imm_form.opcode;
    assign imm_en = instr.imm_form.imm_en;
    assign ra     = instr.imm_form.ra;
    assign imm8   = instr.imm_form.imm8;
    assign rb     = instr.reg_form.rb;
    assign rc     = instr.reg_form.rc;

    always_comb begin
        reg_we_raw = 1'b0;
        mem_we_raw = 1'b0;
        flags_we   = 1'b0;
        case (opcode)
            op_mov, op_add, op_sub, op_adc, op_sbc: begin
                reg_we_raw = 1'b1;
                flags_we   = 1'b1;
            end
            // compare only sets flags
            op_cmp:   flags_we   = 1'b1;
            op_load:  reg_we_raw = 1'b1;
            op_store: mem_we_raw = 1'b1;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== cpu_pkg.sv ====
// RISC8 shared definitions
`default_nettype none

package cpu_pkg;

    localparam int data_width     = 8;
    localparam int addr_width     = 8;
    localparam int pc_width       = 16;
    localparam int rom_depth      = 256;
    localparam int reg_count      = 8;
    localparam int reg_addr_width = 3;
    localparam int opcode_width   = 4;

    // opcodes E and F are unassigned and run as no-ops
    localparam logic [opcode_width-1:0] op_mov   = 4'h0;
    localparam logic [opcode_width-1:0] op_add   = 4'h1;
    localparam logic [opcode_width-1:0] op_sub   = 4'h2;
    localparam logic [opcode_width-1:0] op_jmp   = 4'h3;
    localparam logic [opcode_width-1:0] op_load  = 4'h4;
    localparam logic [opcode_width-1:0] op_store = 4'h5;
    localparam logic [opcode_width-1:0] op_adc   = 4'h6;
    localparam logic [opcode_width-1:0] op_sbc   = 4'h7;
    localparam logic [opcode_width-1:0] op_cmp   = 4'h8;
    localparam logic [opcode_width-1:0] op_jz    = 4'h9;
    localparam logic [opcode_width-1:0] op_jc    = 4'hA;
    localparam logic [opcode_width-1:0] op_jn    = 4'hB;
    localparam logic [opcode_width-1:0] op_jge   = 4'hC;
    localparam logic [opcode_width-1:0] op_jgt   = 4'hD;

    // bit 11 is imm_en for data ops and the condition invert for jumps
    typedef union packed {
        // three-register form
        struct packed {
            logic [opcode_width-1:0]   opcode;
            logic                      imm_en;
            logic [reg_addr_width-1:0] ra;
            logic [reg_addr_width-1:0] rb;
            logic [reg_addr_width-1:0] rc;
            logic [1:0]                pad;
        } reg_form;
        // register plus 8-bit immediate, also the jump offset
        struct packed {
            logic [opcode_width-1:0]   opcode;
            logic                      imm_en;
            logic [reg_addr_width-1:0] ra;
            logic [data_width-1:0]     imm8;
        } imm_form;
    } instr_t;

endpackage

`default_nettype wire
